// File: files.f
verilog/br_pkg.sv
verilog/br_mask_ctrl.sv
verilog/br_ckpt_entry.sv
verilog/br_recovery_sel.sv
verilog/branch_stack.sv
verification/branch_stack_tb.sv

// File: verification/branch_stack_golden.txt
# C rst br cond state tag dep cdb_vld cdb_tag dc seed fl sq rdy | alloc mask full rc_vld rc_fl rc_sq rc_rdy rc_seed
# T <num> <name> opens a test; state 0 none 1 correct 2 wrong; dc 1 means random snapshot.
T 1 after_reset
C 1 0 0 0 0 0 0 00 0 00 00 0 00 0 0 0 0 00 0 00 00

T 2 uncond_branch
C 1 1 0 0 0 0 0 00 0 3c 1f 7 aa 0 0 0 0 00 0 00 00
C 1 0 1 0 0 0 0 00 0 3c 1f 7 aa 0 0 0 0 00 0 00 00

T 3 fill_to_full
C 1 1 1 0 0 0 0 00 0 10 01 1 ff 1 1 0 0 00 0 00 00
C 1 1 1 0 0 0 0 00 0 20 02 2 ff 2 3 0 0 00 0 00 00
C 1 1 1 0 0 0 1 34 0 30 03 3 0f 4 7 0 0 00 0 00 00
C 1 1 1 0 0 0 0 00 0 18 04 4 ff 8 f 1 0 00 0 00 00
C 1 1 1 0 0 0 0 00 1 00 00 0 00 0 f 1 0 00 0 00 00

T 4 correct_resolve_reuse
C 1 0 0 1 8 7 0 00 0 00 00 0 00 0 7 0 0 00 0 00 00
C 1 1 1 1 2 1 0 00 0 28 05 5 ff 2 7 0 0 00 0 00 00

T 5 cdb_ready_tracking
C 1 0 0 0 0 0 1 35 0 00 00 0 00 0 7 0 0 00 0 00 00
C 1 0 0 0 0 0 1 3f 0 00 00 0 00 0 7 0 0 00 0 00 00

T 6 wrong_resolve_recovery
C 1 1 1 2 4 3 0 00 1 00 00 0 00 0 3 0 1 03 3 3f 30
C 1 0 0 0 0 0 0 00 0 00 00 0 00 0 3 0 0 00 0 00 00
C 1 0 0 2 2 1 0 00 0 00 00 0 00 0 1 0 1 05 5 ff 28

T 7 reset_clears
C 0 0 0 0 0 0 0 00 0 00 00 0 00 0 0 0 0 00 0 00 00
C 1 0 0 0 0 0 0 00 0 00 00 0 00 0 0 0 0 00 0 00 00
C 1 1 1 0 0 0 0 00 1 00 00 0 00 1 1 0 0 00 0 00 00

// File: verification/branch_stack_tb.sv
// Self-checking testbench for the branch stack; replays the golden file, one record per clock.
`timescale 1ns/1ps
`default_nettype none

module branch_stack_tb;

	import br_pkg::*;

	localparam int MAX_PHASE_CYC = 64;		// Cycles a test may run before its next marker.
	localparam int MAX_LINES     = 1000;		// Bound on the file read loop.

	// Inputs for one cycle.
	typedef struct packed {
		logic        rst_n;
		logic        is_br;
		logic        is_cond;
		br_resolve_t resolve;
		cdb_t        cdb;
		ckpt_t       snap;
	} stim_t;

	// Expected responses for one record.
	typedef struct packed {
		logic [BR_MASK_W-1:0] alloc;		// Same cycle.
		logic [BR_MASK_W-1:0] mask;		// After the clock.
		logic                 full;		// After the clock.
		logic                 rc_vld;		// Same cycle.
		ckpt_t                rc;		// Same cycle.
	} expect_t;

	logic                 clk;
	logic                 rst_n_i;
	logic                 is_br_i;
	logic                 is_cond_i;
	br_resolve_t          resolve_i;
	cdb_t                 cdb_i;
	ckpt_t                snap_i;
	logic [BR_MASK_W-1:0] br_mask_o;
	logic [BR_MASK_W-1:0] br_alloc_bit_o;
	logic [BR_MASK_W-1:0] br_bit_o;
	logic                 full_o;
	ckpt_t                rc_o;
	logic                 rc_vld_o;

	integer           seed = 17;			// Filler snapshots only.
	int               checks;
	int               errors;
	int               test_checks;
	int               test_errs;
	int               tests_done;
	int               test_num;
	logic [8*32-1:0]  test_name;
	logic             pend_vld;			// Registered results still owed a check.
	expect_t          pend;

	branch_stack dut_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.is_br_i        (is_br_i),
		.is_cond_i      (is_cond_i),
		.resolve_i      (resolve_i),
		.cdb_i          (cdb_i),
		.snap_i         (snap_i),
		.br_mask_o      (br_mask_o),
		.br_alloc_bit_o (br_alloc_bit_o),
		.br_bit_o       (br_bit_o),
		.full_o         (full_o),
		.rc_o           (rc_o),
		.rc_vld_o       (rc_vld_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;			// 10 ns period.
	end

	// Slot i gets tag seed+i; ready bits come straight from the record.
	function automatic ckpt_t build_snap(input logic [7:0] sd, input logic [7:0] fl,
		input logic [7:0] sq, input logic [7:0] rdy);
		ckpt_t c;
		for (int i = 0; i < MT_NUM; i++) begin
			c.mt[i].rdy = rdy[i];
			c.mt[i].tag = sd[PRF_IDX_W-1:0] + PRF_IDX_W'(i);
		end
		c.fl_head = fl[FL_PTR_W:0];
		c.sq_tail = sq[SQ_IDX_W:0];
		return c;
	endfunction

	task automatic check_val(input string sig, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", sig, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	// One clock: drive on the rising edge, sample at the falling edge.
	task automatic run_cycle(input stim_t s, input expect_t e, input logic comb_chk);
		logic [BR_MASK_W-1:0] exp_bit;
		exp_bit = '0;
		if (s.resolve.state == BR_CORRECT || s.resolve.state == BR_WRONG)
			exp_bit = s.resolve.tag;	// Resolved branch's bit, either outcome.
		@(posedge clk);
		rst_n_i   <= s.rst_n;
		is_br_i   <= s.is_br;
		is_cond_i <= s.is_cond;
		resolve_i <= s.resolve;
		cdb_i     <= s.cdb;
		snap_i    <= s.snap;
		@(negedge clk);
		if (pend_vld) begin			// Mask and full of the previous record.
			check_val("br_mask_o", 64'(br_mask_o), 64'(pend.mask));
			check_val("full_o", 64'(full_o), 64'(pend.full));
		end
		pend_vld = comb_chk;
		pend     = e;
		if (comb_chk) begin
			check_val("br_alloc_bit_o", 64'(br_alloc_bit_o), 64'(e.alloc));
			check_val("br_bit_o", 64'(br_bit_o), 64'(exp_bit));
			check_val("rc_vld_o", 64'(rc_vld_o), 64'(e.rc_vld));
			check_val("rc_o.fl_head", 64'(rc_o.fl_head), 64'(e.rc.fl_head));
			check_val("rc_o.sq_tail", 64'(rc_o.sq_tail), 64'(e.rc.sq_tail));
			check_val("rc_o.mt", 64'(rc_o.mt), 64'(e.rc.mt));	// Ready bits and tags.
		end
	endtask

	// Idle clock that settles the last record's registered checks.
	task automatic flush();
		stim_t idle;
		idle       = '0;
		idle.rst_n = 1'b1;
		run_cycle(idle, '0, 1'b0);
	endtask

	task automatic close_test();
		tests_done++;
		$display("Test %0d %0s: %0d checks, %0d errors", test_num, test_name,
			test_checks, test_errs);
	endtask

	initial begin : main
		integer           fd;
		int               n_read;
		int               n_lines;
		int               phase_cyc;
		logic             test_open;
		logic             done;
		logic             aborted;
		logic [8*128-1:0] line_r;
		logic [8*16-1:0]  tok;
		logic [95:0]      rnd;
		stim_t            s;
		expect_t          e;
		logic [7:0]       f_rst, f_br, f_cond, f_st, f_tag, f_dep, f_cvld;
		logic [7:0]       f_ctag, f_dc, f_sd, f_fl, f_sq, f_rdy;
		logic [7:0]       x_alloc, x_mask, x_full, x_rvld, x_fl, x_sq, x_rdy, x_sd;

		rst_n_i     = 1'b0;			// Reset held from time zero.
		is_br_i     = 1'b0;
		is_cond_i   = 1'b0;
		resolve_i   = '0;
		cdb_i       = '0;
		snap_i      = '0;
		checks      = 0;
		errors      = 0;
		tests_done  = 0;
		test_checks = 0;
		test_errs   = 0;
		test_num    = 0;
		test_name   = '0;
		pend_vld    = 1'b0;
		pend        = '0;
		n_lines     = 0;
		phase_cyc   = 0;
		test_open   = 1'b0;
		done        = 1'b0;
		aborted     = 1'b0;

		repeat (4) @(posedge clk);
		@(posedge clk);
		rst_n_i <= 1'b1;			// Fifth edge still sees reset low.

		fd = $fopen("verification/branch_stack_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file verification/branch_stack_golden.txt");
			aborted = 1'b1;
		end

		while (!done && !aborted) begin
			n_lines++;
			line_r = '0;
			tok    = '0;
			if (n_lines > MAX_LINES) begin
				$display("Golden file ran past %0d lines, reading stopped", MAX_LINES);
				aborted = 1'b1;
			end else begin
				n_read = $fgets(line_r, fd);
				if (n_read == 0)
					done = 1'b1;		// End of file.
				else
					n_read = $sscanf(line_r, "%s", tok);
				if (done || n_read != 1) begin
					// Blank line or end of file.
				end else if (tok == "T") begin
					if (test_open) begin
						flush();
						close_test();
					end
					test_name   = '0;
					n_read      = $sscanf(line_r, "%s %d %s", tok, test_num, test_name);
					test_open   = 1'b1;
					test_checks = 0;
					test_errs   = 0;
					phase_cyc   = 0;
				end else if (tok == "C") begin
					n_read = $sscanf(line_r,
						"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						tok, f_rst, f_br, f_cond, f_st, f_tag, f_dep, f_cvld, f_ctag,
						f_dc, f_sd, f_fl, f_sq, f_rdy, x_alloc, x_mask, x_full, x_rvld,
						x_fl, x_sq, x_rdy, x_sd);
					if (n_read != 22) begin
						$display("Malformed record in test %0d, line %0d", test_num, n_lines);
						errors++;
						test_errs++;
					end else begin
						s.rst_n            = f_rst[0];
						s.is_br            = f_br[0];
						s.is_cond          = f_cond[0];
						s.resolve.state    = br_state_e'(f_st[1:0]);
						s.resolve.tag      = f_tag[BR_MASK_W-1:0];
						s.resolve.dep_mask = f_dep[BR_MASK_W-1:0];
						s.cdb.vld          = f_cvld[0];
						s.cdb.tag          = f_ctag[PRF_IDX_W-1:0];
						if (f_dc[0]) begin
							rnd    = {$random(seed), $random(seed), $random(seed)};
							s.snap = rnd[$bits(ckpt_t)-1:0];	// Don't care filler.
						end else
							s.snap = build_snap(f_sd, f_fl, f_sq, f_rdy);
						e.alloc  = x_alloc[BR_MASK_W-1:0];
						e.mask   = x_mask[BR_MASK_W-1:0];
						e.full   = x_full[0];
						e.rc_vld = x_rvld[0];
						e.rc     = x_rvld[0] ? build_snap(x_sd, x_fl, x_sq, x_rdy) : '0;
						run_cycle(s, e, 1'b1);
						phase_cyc++;
						if (phase_cyc > MAX_PHASE_CYC) begin
							$display("Test %0d ran past %0d cycles without a next marker",
								test_num, MAX_PHASE_CYC);
							aborted = 1'b1;
						end
					end
				end else if (tok != "#") begin
					$display("Unknown record kind on golden file line %0d", n_lines);
					errors++;
				end
			end
		end

		if (test_open) begin
			flush();
			close_test();
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
		if (!aborted && errors == 0 && tests_done > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/br_ckpt_entry.sv
// One branch checkpoint; snapshots rename state at allocation and tracks CDB ready bits while live.
`timescale 1ns/1ps
`default_nettype none

module br_ckpt_entry (
	input  logic          clk,
	input  logic          rst_n_i,
	input  logic          alloc_i,	// This entry's bit granted this cycle.
	input  logic          free_i,	// Entry's bit is out of the mask.
	input  br_pkg::ckpt_t snap_i,	// Live map table, free-list head, SQ tail.
	input  br_pkg::cdb_t  cdb_i,	// Result broadcast.
	output br_pkg::ckpt_t ckpt_o,	// Saved state.
	output logic          vld_o	// Entry belongs to an in-flight branch.
);

	import br_pkg::*;

	ckpt_t ckpt_q;			// Saved snapshot, payload only.
	ckpt_t ckpt_d;
	logic  vld_q;			// Set on allocation.
	logic  live;			// Valid and still in the mask.

	// Mask drops the bit one clock before vld_q follows, so gate here.
	// Keeps the entry reusable in the very cycle its bit frees up.
	assign live = vld_q & ~free_i;

	// Snapshot source, with this cycle's broadcast folded in.
	always_comb begin
		ckpt_d = alloc_i ? snap_i : ckpt_q;
		for (int i = 0; i < MT_NUM; i++) begin
			if (cdb_i.vld && (ckpt_d.mt[i].tag == cdb_i.tag))
				ckpt_d.mt[i].rdy = 1'b1;	// Producer finished.
		end
	end

	// Payload updates on load or while tracking the CDB.
	always_ff @(posedge clk) begin
		if (alloc_i || live)
			ckpt_q <= ckpt_d;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			vld_q <= 1'b0;
		else if (alloc_i)
			vld_q <= 1'b1;		// Load wins over a stale free.
		else if (free_i)
			vld_q <= 1'b0;		// Resolved or squashed.
	end

	assign ckpt_o = ckpt_q;
	assign vld_o  = live;

	// A live entry is reloaded only when its branch resolves correct in that cycle,
	// and a branch never resolves in the cycle right after its own dispatch.
	a_no_reload: assert property (@(posedge clk) disable iff (!rst_n_i)
		(alloc_i && live) |-> !$past(alloc_i))
		else $error("checkpoint loaded while still valid");

endmodule

`default_nettype wire

// File: verilog/br_mask_ctrl.sv
// Branch mask controller; allocates, frees and rolls back checkpoint bits for the branch stack.
`timescale 1ns/1ps
`default_nettype none

module br_mask_ctrl (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          is_br_i,		// Branch in dispatch.
	input  logic                          is_cond_i,	// Only conditional ones get a checkpoint.
	input  br_pkg::br_resolve_t           resolve_i,	// Outcome from the ROB.
	output logic [br_pkg::BR_MASK_W-1:0]  br_mask_o,	// Registered in-flight mask.
	output logic [br_pkg::BR_MASK_W-1:0]  alloc_bit_o,	// One-hot grant, dispatch cycle only.
	output logic                          full_o		// All checkpoints taken.
);

	import br_pkg::*;

	logic [BR_MASK_W-1:0] mask_q;		// In-flight branches.
	logic [BR_MASK_W-1:0] mask_clr;		// Mask after a correct resolve this cycle.
	logic [BR_MASK_W-1:0] free_bit;		// Lowest zero bit of mask_clr.
	logic [BR_MASK_W-1:0] mask_d;
	logic                 full_q;
	logic                 alloc_req;	// Conditional dispatch that may be granted.
	logic                 is_wrong;
	logic                 is_correct;

	assign is_wrong   = (resolve_i.state == BR_WRONG);
	assign is_correct = (resolve_i.state == BR_CORRECT);

	// Mispredict squashes the dispatching branch, so it gets nothing.
	assign alloc_req = is_br_i & is_cond_i & ~full_q & ~is_wrong;

	// A correct resolve frees its bit early enough to be reused in the same cycle.
	always_comb begin
		mask_clr = mask_q;
		if (is_correct)
			mask_clr = mask_q & ~resolve_i.tag;
	end

	// Priority pick of the lowest free bit.
	always_comb begin
		logic found;
		found    = 1'b0;
		free_bit = '0;
		for (int i = 0; i < BR_MASK_W; i++) begin
			if (!found && !mask_clr[i]) begin
				free_bit[i] = 1'b1;
				found       = 1'b1;
			end
		end
	end

	assign alloc_bit_o = alloc_req ? free_bit : '0;	// Not full, so a zero bit exists.

	// Next mask.
	always_comb begin
		if (is_wrong)
			// Back to the branch's view at dispatch; bits freed since then stay free
			// since their entries are gone.
			mask_d = resolve_i.dep_mask & mask_q;
		else
			mask_d = mask_clr | alloc_bit_o;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mask_q <= '0;
			full_q <= 1'b0;
		end else begin
			mask_q <= mask_d;
			full_q <= &mask_d;		// Full flag kept as a flop beside the mask.
		end
	end

	assign br_mask_o = mask_q;
	assign full_o    = full_q;

	// No grant while every mask bit is taken.
	a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		(&mask_q) |-> (alloc_bit_o == '0))
		else $error("checkpoint granted while full");

	// ROB may only resolve a branch that still holds a checkpoint.
	a_resolve_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
		(resolve_i.state != BR_NONE) |-> ($onehot(resolve_i.tag) && |(resolve_i.tag & mask_q)))
		else $error("resolve tag not one-hot or not in flight");

endmodule

`default_nettype wire

// File: verilog/br_pkg.sv
// Shared widths, resolve encoding and snapshot structs; import into every branch stack file.
`default_nettype none

package br_pkg;

	// Stack geometry.
	localparam int BR_MASK_W = 4;			// Checkpoints, one mask bit each.
	localparam int MT_NUM    = 8;			// Architectural registers in the map table.
	localparam int PRF_IDX_W = 6;			// Physical register tag width.
	localparam int FL_PTR_W  = 5;			// Free-list pointer, stored with a wrap bit.
	localparam int SQ_IDX_W  = 3;			// Store-queue index, stored with a wrap bit.

	// Resolve state sent by the ROB with each branch outcome.
	typedef enum logic [1:0] {
		BR_NONE    = 2'b00,				// No branch resolves this cycle.
		BR_CORRECT = 2'b01,				// Prediction held, free the checkpoint.
		BR_WRONG   = 2'b10				// Mispredicted, roll back and recover.
	} br_state_e;

	// One map table slot.
	typedef struct packed {
		logic                 rdy;		// Value present in the PRF.
		logic [PRF_IDX_W-1:0] tag;		// Physical register holding the value.
	} map_ent_t;

	// Full snapshot saved per checkpoint, 66 bits.
	typedef struct packed {
		map_ent_t [MT_NUM-1:0] mt;		// Map table with ready bits.
		logic [FL_PTR_W:0]     fl_head;		// Free-list head incl. wrap bit.
		logic [SQ_IDX_W:0]     sq_tail;		// Store-queue tail incl. wrap bit.
	} ckpt_t;

	// Branch outcome from the ROB.
	// The dependency mask is the mask the branch saw when it was dispatched,
	// so it never holds the branch's own bit.
	typedef struct packed {
		br_state_e            state;		// Outcome this cycle.
		logic [BR_MASK_W-1:0] tag;		// One-hot bit of the resolved branch.
		logic [BR_MASK_W-1:0] dep_mask;		// Mask at dispatch time.
	} br_resolve_t;

	// Common data bus broadcast.
	typedef struct packed {
		logic                 vld;		// Broadcast present.
		logic [PRF_IDX_W-1:0] tag;		// Tag that became ready.
	} cdb_t;

endpackage

`default_nettype wire

// File: verilog/br_recovery_sel.sv
// Recovery mux for the branch stack; drives out the snapshot of a mispredicted branch.
`timescale 1ns/1ps
`default_nettype none

module br_recovery_sel (
	input  br_pkg::ckpt_t [br_pkg::BR_MASK_W-1:0] ckpt_i,	// All saved snapshots.
	input  logic [br_pkg::BR_MASK_W-1:0]          vld_i,	// Live entries.
	input  br_pkg::br_resolve_t                   resolve_i,	// Outcome from the ROB.
	output br_pkg::ckpt_t                         rc_o,	// Recovery data.
	output logic                                  rc_vld_o	// Recovery strobe.
);

	import br_pkg::*;

	logic                 is_wrong;
	logic [BR_MASK_W-1:0] sel;		// Tag masked by live entries.

	assign is_wrong = (resolve_i.state == BR_WRONG);
	assign sel      = is_wrong ? (resolve_i.tag & vld_i) : '0;

	// Tag is one-hot, so at most one entry hits.
	always_comb begin
		rc_o = '0;				// Zero when nothing to recover.
		for (int k = 0; k < BR_MASK_W; k++) begin
			if (sel[k])
				rc_o = ckpt_i[k];
		end
	end

	assign rc_vld_o = |sel;

	// A mispredict must point at a checkpoint that still holds state.
	always_comb begin
		if (is_wrong) begin
			a_sel_valid: assert final (|(resolve_i.tag & vld_i))
				else $error("recovery from an invalid checkpoint");
		end
	end

endmodule

`default_nettype wire

// File: verilog/branch_stack.sv
// Branch checkpoint stack top; wires the mask controller, four checkpoint entries and recovery mux.
`timescale 1ns/1ps
`default_nettype none

module branch_stack (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          is_br_i,		// Dispatch: branch insn.
	input  logic                          is_cond_i,	// Dispatch: conditional.
	input  br_pkg::br_resolve_t           resolve_i,	// ROB: branch outcome.
	input  br_pkg::cdb_t                  cdb_i,		// CDB broadcast.
	input  br_pkg::ckpt_t                 snap_i,		// Map table, FL head, SQ tail now.
	output logic [br_pkg::BR_MASK_W-1:0]  br_mask_o,	// ROB: mask for the dispatching insn.
	output logic [br_pkg::BR_MASK_W-1:0]  br_alloc_bit_o,	// ROB: bit given to this branch.
	output logic [br_pkg::BR_MASK_W-1:0]  br_bit_o,		// RS: resolved branch bit.
	output logic                          full_o,		// Dispatch stall.
	output br_pkg::ckpt_t                 rc_o,		// Recovery snapshot.
	output logic                          rc_vld_o		// Recovery strobe.
);

	import br_pkg::*;

	logic [BR_MASK_W-1:0]          alloc_bit;	// One-hot grant.
	logic [BR_MASK_W-1:0]          mask;		// Registered mask.
	logic [BR_MASK_W-1:0]          ckpt_vld;	// Live entries.
	ckpt_t [BR_MASK_W-1:0]         ckpt_all;	// All saved snapshots.

	br_mask_ctrl u_mask_ctrl (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.is_br_i     (is_br_i),
		.is_cond_i   (is_cond_i),
		.resolve_i   (resolve_i),
		.br_mask_o   (mask),
		.alloc_bit_o (alloc_bit),
		.full_o      (full_o)
	);

	// One entry per mask bit; an entry frees once its bit is gone from the mask.
	for (genvar k = 0; k < BR_MASK_W; k++) begin : g_ent
		br_ckpt_entry u_ent (
			.clk     (clk),
			.rst_n_i (rst_n_i),
			.alloc_i (alloc_bit[k]),
			.free_i  (~mask[k]),
			.snap_i  (snap_i),
			.cdb_i   (cdb_i),
			.ckpt_o  (ckpt_all[k]),
			.vld_o   (ckpt_vld[k])
		);
	end

	br_recovery_sel u_rc_sel (
		.ckpt_i    (ckpt_all),
		.vld_i     (ckpt_vld),
		.resolve_i (resolve_i),
		.rc_o      (rc_o),
		.rc_vld_o  (rc_vld_o)
	);

	assign br_mask_o      = mask;	// Pre-allocation mask is the new branch's dependency.
	assign br_alloc_bit_o = alloc_bit;

	// RS needs the bit as soon as the outcome is known, both ways.
	assign br_bit_o = (resolve_i.state != BR_NONE) ? resolve_i.tag : '0;

endmodule

`default_nettype wire
